/* common/qspi_cfg.svh */
`ifndef QSPI_CFG_SVH
`define QSPI_CFG_SVH

// flash opcodes
`define QSPI_OP_WREN    8'h06   // write enable
`define QSPI_OP_RDSR    8'h05   // read status register
`define QSPI_OP_SE      8'h20   // sector erase
`define QSPI_OP_PP      8'h02   // page program
`define QSPI_OP_READ    8'h03   // read data, single lane
`define QSPI_OP_QREAD   8'h6B   // quad output read

// transfer geometry
`define QSPI_ADDR_W     24      // flash address bits
`define QSPI_DUMMY_CLKS 8       // sclk periods before quad data
`define QSPI_SCLK_DIV   2       // system clocks per sclk period

`endif

/* common/qspi_pkg.sv */
package qspi_pkg;

    // command types seen at the user port
    typedef enum logic [2:0]
    {
        CMD_WREN  = 3'd0,
        CMD_RDSR  = 3'd1,
        CMD_SE    = 3'd2,
        CMD_PP    = 3'd3,
        CMD_READ  = 3'd4,
        CMD_QREAD = 3'd5
    } cmd_type_e;

    typedef enum logic
    {
        LANE_SINGLE = 1'b0,     // io0 out, io1 in
        LANE_QUAD   = 1'b1      // io3..io0, high nibble first
    } lane_mode_e;

    // sequencer phases
    typedef enum logic [2:0]
    {
        IDLE, CMD, ADDR, WDATA, DUMMY, RDATA, FINISH
    } seq_state_e;

endpackage

/* qspi_phy/qspi_shifter.sv */
`timescale 1ns/1ps
`include "qspi_cfg.svh"

module qspi_shifter
(
    input  logic                    I_clk_25M,
    input  logic                    I_rst_n,
    input  logic                    sclk_run,
    input  logic                    load,
    input  logic [`QSPI_ADDR_W-1:0] tx_word,
    input  logic [4:0]              tx_bits,
    input  qspi_pkg::lane_mode_e    lane_mode,
    input  logic                    drive_en,
    output logic                    shift_done,
    output logic                    sample_tick,
    output logic                    qspi_sclk,
    output logic [3:0]              io_out,
    output logic [3:0]              io_oe
);

    localparam logic [3:0] HALF_LAST = 4'(`QSPI_SCLK_DIV / 2 - 1);

    logic                    sclk_q;
    logic                    active;
    logic [4:0]              bit_cnt;       // bit times left
    logic [3:0]              div_cnt;
    logic [`QSPI_ADDR_W-1:0] shreg;
    logic                    edge_en;
    logic                    quad;

    assign quad        = (lane_mode == qspi_pkg::LANE_QUAD);
    assign edge_en     = active & sclk_run & (div_cnt == HALF_LAST);
    assign sample_tick = edge_en & ~sclk_q;                     // sclk about to rise
    assign shift_done  = edge_en & sclk_q & (bit_cnt == 5'd1);  // last falling edge next
    assign qspi_sclk   = sclk_q;

    // msb first, high nibble on io3..io0 in quad
    assign io_out = quad ? shreg[`QSPI_ADDR_W-1 -: 4] : {3'b000, shreg[`QSPI_ADDR_W-1]};
    assign io_oe  = (active & drive_en) ? (quad ? 4'hF : 4'h1) : 4'h0;

    //////////////////////////////////////////////////
    // sclk divider and bit counter
    //////////////////////////////////////////////////
    always_ff @(posedge I_clk_25M)
    begin
        if (!I_rst_n)
        begin
            sclk_q  <= 1'b0;
            active  <= 1'b0;
            bit_cnt <= 5'd0;
            div_cnt <= 4'd0;
        end
        else if (load)
        begin
            sclk_q  <= 1'b0;            // first bit sits on the pins with sclk low
            active  <= 1'b1;
            bit_cnt <= tx_bits;
            div_cnt <= 4'd0;
        end
        else if (active && sclk_run)
        begin
            div_cnt <= edge_en ? 4'd0 : div_cnt + 4'd1;
            if (edge_en)
            begin
                sclk_q <= ~sclk_q;
                if (sclk_q)
                begin
                    bit_cnt <= bit_cnt - 5'd1;
                    if (bit_cnt == 5'd1)
                        active <= 1'b0;
                end
            end
        end
    end

    // data moves on the falling edge
    always_ff @(posedge I_clk_25M)
    begin
        if (load)
            shreg <= tx_word;
        else if (edge_en && sclk_q)
            shreg <= quad ? (shreg << 4) : (shreg << 1);
    end

endmodule

/* qspi_phy/qspi_capture.sv */
`timescale 1ns/1ps

module qspi_capture
(
    input  logic                 I_clk_25M,
    input  logic                 I_rst_n,
    input  logic                 read_en,
    input  qspi_pkg::lane_mode_e lane_mode,
    input  logic                 sample_tick,
    input  logic [3:0]           io_in,
    output logic                 byte_valid,
    output logic [7:0]           read_data
);

    logic [7:0] shreg;
    logic [3:0] bit_cnt;
    logic [3:0] step;
    logic [7:0] assembled;
    logic       quad;

    assign quad      = (lane_mode == qspi_pkg::LANE_QUAD);
    assign step      = quad ? 4'd4 : 4'd1;
    assign assembled = quad ? {shreg[3:0], io_in} : {shreg[6:0], io_in[1]};  // single reads io1

    always_ff @(posedge I_clk_25M)
    begin
        if (!I_rst_n)
        begin
            bit_cnt    <= 4'd0;
            byte_valid <= 1'b0;
        end
        else if (!read_en)
        begin
            bit_cnt    <= 4'd0;         // ready for the next read
            byte_valid <= 1'b0;
        end
        else if (sample_tick)
        begin
            bit_cnt    <= (bit_cnt + step == 4'd8) ? 4'd0 : bit_cnt + step;
            byte_valid <= (bit_cnt + step == 4'd8);
        end
        else
            byte_valid <= 1'b0;
    end

    // byte assembly, held until the next read completes
    always_ff @(posedge I_clk_25M)
    begin
        if (read_en && sample_tick)
        begin
            shreg <= assembled;
            if (bit_cnt + step == 4'd8)
                read_data <= assembled;
        end
    end

endmodule

/* verilog/qspi_sequencer.sv */
`timescale 1ns/1ps
`include "qspi_cfg.svh"

module qspi_sequencer
(
    input  logic                    I_clk_25M,
    input  logic                    I_rst_n,
    input  logic                    start,
    input  qspi_pkg::cmd_type_e     cmd_type,
    input  logic [`QSPI_ADDR_W-1:0] addr,
    input  logic [7:0]              wr_data,
    output logic                    busy,
    output logic                    done,
    output logic                    qspi_cs_n,
    output logic                    sclk_run,
    output logic                    load,
    output logic [`QSPI_ADDR_W-1:0] tx_word,
    output logic [4:0]              tx_bits,
    output qspi_pkg::lane_mode_e    lane_mode,
    output logic                    drive_en,
    input  logic                    shift_done,
    output logic                    read_en,
    input  logic                    byte_valid
);

    localparam int PAD_W = `QSPI_ADDR_W - 8;

    qspi_pkg::seq_state_e    state;
    qspi_pkg::seq_state_e    nxt_state;
    qspi_pkg::cmd_type_e     cmd_q;
    logic [`QSPI_ADDR_W-1:0] addr_q;
    logic [7:0]              data_q;
    qspi_pkg::lane_mode_e    nxt_lane;
    logic                    nxt_drive;

    function automatic logic [7:0] op_of(input qspi_pkg::cmd_type_e c);
        case (c)
            qspi_pkg::CMD_RDSR:  return `QSPI_OP_RDSR;
            qspi_pkg::CMD_SE:    return `QSPI_OP_SE;
            qspi_pkg::CMD_PP:    return `QSPI_OP_PP;
            qspi_pkg::CMD_READ:  return `QSPI_OP_READ;
            qspi_pkg::CMD_QREAD: return `QSPI_OP_QREAD;
            default:             return `QSPI_OP_WREN;
        endcase
    endfunction

    //////////////////////////////////////////////////
    // next phase select, load lands on the last sclk high
    //////////////////////////////////////////////////
    always_comb
    begin
        nxt_state = state;
        load      = 1'b0;
        tx_word   = '0;
        tx_bits   = 5'd0;
        nxt_lane  = qspi_pkg::LANE_SINGLE;
        nxt_drive = 1'b1;
        case (state)
            qspi_pkg::IDLE:
                if (start)
                begin
                    load      = 1'b1;
                    tx_word   = {op_of(cmd_type), {PAD_W{1'b0}}};  // opcode left aligned
                    tx_bits   = 5'd8;
                    nxt_state = qspi_pkg::CMD;
                end
            qspi_pkg::CMD:
                if (shift_done)
                begin
                    if (cmd_q == qspi_pkg::CMD_WREN)
                        nxt_state = qspi_pkg::FINISH;
                    else if (cmd_q == qspi_pkg::CMD_RDSR)
                    begin
                        load      = 1'b1;       // status byte straight after opcode
                        tx_bits   = 5'd8;
                        nxt_drive = 1'b0;
                        nxt_state = qspi_pkg::RDATA;
                    end
                    else
                    begin
                        load      = 1'b1;
                        tx_word   = addr_q;
                        tx_bits   = 5'(`QSPI_ADDR_W);
                        nxt_state = qspi_pkg::ADDR;
                    end
                end
            qspi_pkg::ADDR:
                if (shift_done)
                begin
                    case (cmd_q)
                        qspi_pkg::CMD_PP:
                        begin
                            load      = 1'b1;
                            tx_word   = {data_q, {PAD_W{1'b0}}};
                            tx_bits   = 5'd8;
                            nxt_state = qspi_pkg::WDATA;
                        end
                        qspi_pkg::CMD_READ:
                        begin
                            load      = 1'b1;
                            tx_bits   = 5'd8;
                            nxt_drive = 1'b0;
                            nxt_state = qspi_pkg::RDATA;
                        end
                        qspi_pkg::CMD_QREAD:
                        begin
                            load      = 1'b1;   // clocks only, pins released
                            tx_bits   = 5'(`QSPI_DUMMY_CLKS);
                            nxt_drive = 1'b0;
                            nxt_state = qspi_pkg::DUMMY;
                        end
                        default: nxt_state = qspi_pkg::FINISH;  // sector erase
                    endcase
                end
            qspi_pkg::WDATA:
                if (shift_done)
                    nxt_state = qspi_pkg::FINISH;
            qspi_pkg::DUMMY:
                if (shift_done)
                begin
                    load      = 1'b1;
                    tx_bits   = 5'd2;           // two nibbles
                    nxt_lane  = qspi_pkg::LANE_QUAD;
                    nxt_drive = 1'b0;
                    nxt_state = qspi_pkg::RDATA;
                end
            qspi_pkg::RDATA:
                if (byte_valid)
                    nxt_state = qspi_pkg::FINISH;
            default: nxt_state = qspi_pkg::IDLE;   // FINISH
        endcase
    end

    always_ff @(posedge I_clk_25M)
    begin
        if (!I_rst_n)
        begin
            state     <= qspi_pkg::IDLE;
            busy      <= 1'b0;
            done      <= 1'b0;
            qspi_cs_n <= 1'b1;
            sclk_run  <= 1'b0;
            read_en   <= 1'b0;
            lane_mode <= qspi_pkg::LANE_SINGLE;
            drive_en  <= 1'b0;
        end
        else
        begin
            state <= nxt_state;
            done  <= 1'b0;
            if (load)
            begin
                lane_mode <= nxt_lane;
                drive_en  <= nxt_drive;
            end
            if (state == qspi_pkg::IDLE && start)
            begin
                busy      <= 1'b1;
                qspi_cs_n <= 1'b0;      // cs_n falls with the first bit
                sclk_run  <= 1'b1;
            end
            if (nxt_state == qspi_pkg::RDATA && state != qspi_pkg::RDATA)
                read_en <= 1'b1;
            if (nxt_state == qspi_pkg::FINISH && state != qspi_pkg::FINISH)
            begin
                qspi_cs_n <= 1'b1;
                sclk_run  <= 1'b0;
                read_en   <= 1'b0;
            end
            if (state == qspi_pkg::FINISH)
            begin
                done <= 1'b1;           // one cycle after cs_n rises
                busy <= 1'b0;
            end
        end
    end

    // command latch
    always_ff @(posedge I_clk_25M)
    begin
        if (state == qspi_pkg::IDLE && start)
        begin
            cmd_q  <= cmd_type;
            addr_q <= addr;
            data_q <= wr_data;
        end
    end

endmodule

/* verilog/qspi_top.sv */
`timescale 1ns/1ps
`include "qspi_cfg.svh"

module qspi_top
(
    input  logic                    I_clk_25M,
    input  logic                    I_rst_n,
    input  logic                    start,
    input  qspi_pkg::cmd_type_e     cmd_type,
    input  logic [`QSPI_ADDR_W-1:0] addr,
    input  logic [7:0]              wr_data,
    output logic                    busy,
    output logic                    done,
    output logic [7:0]              read_data,
    output logic                    read_valid,
    output logic                    qspi_sclk,
    output logic                    qspi_cs_n,
    inout  wire  [3:0]              qspi_io
);

    logic                    sclk_run;
    logic                    load;
    logic [`QSPI_ADDR_W-1:0] tx_word;
    logic [4:0]              tx_bits;
    qspi_pkg::lane_mode_e    lane_mode;
    logic                    drive_en;
    logic                    shift_done;
    logic                    sample_tick;
    logic                    read_en;
    logic [3:0]              io_out;
    logic [3:0]              io_oe;

    //////////////////////////////////////////////////
    // pad drivers
    //////////////////////////////////////////////////
    genvar i;
    generate
        for (i = 0; i < 4; i++)
        begin : g_pad
            assign qspi_io[i] = io_oe[i] ? io_out[i] : 1'bz;   // released when not driving
        end
    endgenerate

    qspi_sequencer u_sequencer
    (
        .I_clk_25M  (I_clk_25M),
        .I_rst_n    (I_rst_n),
        .start      (start),
        .cmd_type   (cmd_type),
        .addr       (addr),
        .wr_data    (wr_data),
        .busy       (busy),
        .done       (done),
        .qspi_cs_n  (qspi_cs_n),
        .sclk_run   (sclk_run),
        .load       (load),
        .tx_word    (tx_word),
        .tx_bits    (tx_bits),
        .lane_mode  (lane_mode),
        .drive_en   (drive_en),
        .shift_done (shift_done),
        .read_en    (read_en),
        .byte_valid (read_valid)
    );

    qspi_shifter u_shifter
    (
        .I_clk_25M   (I_clk_25M),
        .I_rst_n     (I_rst_n),
        .sclk_run    (sclk_run),
        .load        (load),
        .tx_word     (tx_word),
        .tx_bits     (tx_bits),
        .lane_mode   (lane_mode),
        .drive_en    (drive_en),
        .shift_done  (shift_done),
        .sample_tick (sample_tick),
        .qspi_sclk   (qspi_sclk),
        .io_out      (io_out),
        .io_oe       (io_oe)
    );

    qspi_capture u_capture
    (
        .I_clk_25M   (I_clk_25M),
        .I_rst_n     (I_rst_n),
        .read_en     (read_en),
        .lane_mode   (lane_mode),
        .sample_tick (sample_tick),
        .io_in       (qspi_io),
        .byte_valid  (read_valid),
        .read_data   (read_data)
    );

endmodule

/* verification/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen
(
    output logic clk,
    output logic rst_n
);

    initial
    begin
        clk   = 1'b0;
        rst_n = 1'b0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;          // low for four rising edges
    end

    always #20 clk = ~clk;      // 40 ns period

endmodule

/* verification/tb_flash_model.sv */
`timescale 1ns/1ps

module tb_flash_model
(
    input  logic        qspi_sclk,
    input  logic        qspi_cs_n,
    inout  wire  [3:0]  qspi_io,
    input  logic [7:0]  resp,
    output logic [7:0]  edges,
    output logic [63:0] rx_bits,
    output logic [15:0] windows,
    output logic        bus_fault
);

    logic [7:0] opcode;
    logic [3:0] drv_val;
    logic [3:0] drv_oe;

    assign qspi_io[0] = drv_oe[0] ? drv_val[0] : 1'bz;
    assign qspi_io[1] = drv_oe[1] ? drv_val[1] : 1'bz;
    assign qspi_io[2] = drv_oe[2] ? drv_val[2] : 1'bz;
    assign qspi_io[3] = drv_oe[3] ? drv_val[3] : 1'bz;

    initial
    begin
        edges     = 8'd0;
        rx_bits   = '0;
        windows   = 16'd0;
        bus_fault = 1'b0;
        opcode    = 8'h00;
        drv_val   = 4'h0;
        drv_oe    = 4'h0;
    end

    //////////////////////////////////////////////////
    // receive side, io0 sampled on rising sclk
    //////////////////////////////////////////////////
    always @(posedge qspi_sclk or negedge qspi_cs_n)
    begin
        if (!qspi_sclk)
        begin
            edges     = 8'd0;               // new chip-select window
            rx_bits   = '0;
            opcode    = 8'h00;
            bus_fault = 1'b0;
            windows   = windows + 16'd1;
        end
        else if (!qspi_cs_n)
        begin
            if (opcode == 8'h6B && edges >= 8'd32 && edges < 8'd40 && qspi_io !== 4'bzzzz)
                bus_fault = 1'b1;           // dummy clocks, every pin floats
            if ((qspi_io & drv_oe) !== (drv_val & drv_oe))
                bus_fault = 1'b1;           // contention on a pin we drive
            if (!drv_oe[1] && qspi_io[1] !== 1'bz)
                bus_fault = 1'b1;           // io1 belongs to the flash
            rx_bits = {rx_bits[62:0], qspi_io[0]};
            edges   = edges + 8'd1;
            if (edges == 8'd8)
                opcode = rx_bits[7:0];
        end
    end

    // response moves on the falling edge
    always @(negedge qspi_sclk or posedge qspi_cs_n)
    begin
        drv_oe = 4'h0;
        if (!qspi_cs_n && opcode == 8'h6B && edges >= 8'd40 && edges < 8'd42)
        begin
            drv_oe  = 4'hF;                 // high nibble first
            drv_val = (edges == 8'd40) ? resp[7:4] : resp[3:0];
        end
        else if (!qspi_cs_n && ((opcode == 8'h05 && edges >= 8'd8 && edges < 8'd16) ||
                 (opcode == 8'h03 && edges >= 8'd32 && edges < 8'd40)))
        begin
            drv_oe  = 4'b0010;
            drv_val = {2'b00, resp[7 - (edges % 8)], 1'b0};
        end
    end

endmodule

/* verification/tb_qspi_top.sv */
`timescale 1ns/1ps

module tb_qspi_top;

    localparam int NUM_VEC     = 14;
    localparam int VEC_COLS    = 5;     // cmd, addr, wr, resp, expected
    localparam int CLK_NS      = 40;
    localparam int DONE_WAIT   = 200;   // cycles per command
    localparam int WATCHDOG_NS = (NUM_VEC * 100 + 200) * CLK_NS;

    logic                I_clk_25M;
    logic                I_rst_n;
    logic                start;
    qspi_pkg::cmd_type_e cmd_type;
    logic [23:0]         addr;
    logic [7:0]          wr_data;
    logic                busy;
    logic                done;
    logic [7:0]          read_data;
    logic                read_valid;
    logic                qspi_sclk;
    logic                qspi_cs_n;
    wire  [3:0]          qspi_io;
    logic [7:0]          resp_byte;
    logic [7:0]          edges;
    logic [63:0]         rx_bits;
    logic [15:0]         windows;
    logic                bus_fault;
    logic [31:0]         vec_mem [0:NUM_VEC*VEC_COLS-1];
    int                  fail_count;
    int                  bad_tests;
    logic                read_seen;
    logic [7:0]          last_read;

    tb_clock_gen u_clk_gen
    (
        .clk   (I_clk_25M),
        .rst_n (I_rst_n)
    );

    qspi_top UUT
    (
        .I_clk_25M  (I_clk_25M),
        .I_rst_n    (I_rst_n),
        .start      (start),
        .cmd_type   (cmd_type),
        .addr       (addr),
        .wr_data    (wr_data),
        .busy       (busy),
        .done       (done),
        .read_data  (read_data),
        .read_valid (read_valid),
        .qspi_sclk  (qspi_sclk),
        .qspi_cs_n  (qspi_cs_n),
        .qspi_io    (qspi_io)
    );

    tb_flash_model u_flash
    (
        .qspi_sclk (qspi_sclk),
        .qspi_cs_n (qspi_cs_n),
        .qspi_io   (qspi_io),
        .resp      (resp_byte),
        .edges     (edges),
        .rx_bits   (rx_bits),
        .windows   (windows),
        .bus_fault (bus_fault)
    );

    function automatic logic [7:0] expected_opcode(input qspi_pkg::cmd_type_e c);
        case (c)
            qspi_pkg::CMD_WREN: return 8'h06;
            qspi_pkg::CMD_RDSR: return 8'h05;
            qspi_pkg::CMD_SE:   return 8'h20;
            qspi_pkg::CMD_PP:   return 8'h02;
            qspi_pkg::CMD_READ: return 8'h03;
            default:            return 8'h6B;
        endcase
    endfunction

    function automatic int expected_edges(input qspi_pkg::cmd_type_e c);
        case (c)
            qspi_pkg::CMD_WREN:                   return 8;
            qspi_pkg::CMD_RDSR:                   return 16;    // opcode and status byte
            qspi_pkg::CMD_SE:                     return 32;
            qspi_pkg::CMD_PP, qspi_pkg::CMD_READ: return 40;
            default:                              return 42;    // 32 + 8 dummy + 2 nibbles
        endcase
    endfunction

    // bits the host itself puts on io0
    function automatic int host_bits(input qspi_pkg::cmd_type_e c);
        case (c)
            qspi_pkg::CMD_WREN, qspi_pkg::CMD_RDSR: return 8;
            qspi_pkg::CMD_PP:                       return 40;
            default:                                return 32;
        endcase
    endfunction

    function automatic logic is_read(input qspi_pkg::cmd_type_e c);
        return (c == qspi_pkg::CMD_RDSR || c == qspi_pkg::CMD_READ || c == qspi_pkg::CMD_QREAD);
    endfunction

    task automatic check_value(input int idx, input string name,
                               input logic [63:0] got, input logic [63:0] want);
        assert (got === want)
        else
        begin
            $display("Fail test %0d %s got %0h expected %0h", idx, name, got, want);
            fail_count++;
        end
    endtask

    task automatic check_reset();
        check_value(0, "qspi_cs_n", qspi_cs_n, 1'b1);
        check_value(0, "qspi_sclk", qspi_sclk, 1'b0);
        check_value(0, "qspi_io", qspi_io, 4'bzzzz);
        check_value(0, "busy", busy, 1'b0);
        check_value(0, "done", done, 1'b0);
        check_value(0, "read_valid", read_valid, 1'b0);
        $display("test 0 reset state %s", (fail_count == 0) ? "ok" : "had errors");
        if (fail_count != 0)
            bad_tests++;
    endtask

    //////////////////////////////////////////////////
    // one command per vector
    //////////////////////////////////////////////////
    task automatic run_test(input int idx);
        qspi_pkg::cmd_type_e c;
        logic [23:0]         a;
        logic [7:0]          w;
        logic [7:0]          r;
        logic [7:0]          e;
        logic [63:0]         sent;
        logic [63:0]         got;
        logic [63:0]         mask;
        int                  n_bits;
        int                  cycles;
        int                  rv_cnt;
        logic [7:0]          rv_data;
        logic                busy_at_done;
        logic                cs_at_done;
        logic                got_done;
        logic [15:0]         win_before;
        int                  fails_before;
        int                  busy_low;
        int                  num;

        c            = qspi_pkg::cmd_type_e'(vec_mem[idx*VEC_COLS][2:0]);
        a            = vec_mem[idx*VEC_COLS+1][23:0];
        w            = vec_mem[idx*VEC_COLS+2][7:0];
        r            = vec_mem[idx*VEC_COLS+3][7:0];
        e            = vec_mem[idx*VEC_COLS+4][7:0];
        num          = idx + 1;
        fails_before = fail_count;
        win_before   = windows;
        rv_cnt       = 0;
        rv_data      = 8'h00;
        cycles       = 0;
        busy_low     = 0;

        repeat ($urandom % 6) @(posedge I_clk_25M);     // idle gap
        @(posedge I_clk_25M);
        start     <= 1'b1;
        cmd_type  <= c;
        addr      <= a;
        wr_data   <= w;
        resp_byte <= r;
        @(posedge I_clk_25M);
        start <= 1'b0;
        repeat (2) @(posedge I_clk_25M);
        start    <= 1'b1;                               // lands while busy
        cmd_type <= qspi_pkg::CMD_QREAD;
        addr     <= ~a;
        @(posedge I_clk_25M);
        start <= 1'b0;

        do
        begin
            @(negedge I_clk_25M);
            cycles++;
            if (!done && busy !== 1'b1)
                busy_low++;
            if (read_valid)
            begin
                rv_cnt++;
                rv_data = read_data;
            end
        end
        while (!done && cycles < DONE_WAIT);
        busy_at_done = busy;
        cs_at_done   = qspi_cs_n;
        got_done     = done;
        @(negedge I_clk_25M);

        assert (got_done === 1'b1)
        else
        begin
            $display("test %0d: no done pulse within %0d cycles", num, DONE_WAIT);
            fail_count++;
        end
        assert (busy_low == 0)
        else
        begin
            $display("test %0d: busy was low for %0d cycles before done", num, busy_low);
            fail_count++;
        end
        check_value(num, "busy", busy_at_done, 1'b0);
        check_value(num, "qspi_cs_n", cs_at_done, 1'b1);
        check_value(num, "done", done, 1'b0);          // one cycle only
        check_value(num, "read_valid pulses", rv_cnt, is_read(c) ? 1 : 0);
        if (is_read(c))
        begin
            check_value(num, "read_data", rv_data, e);
            check_value(num, "read_data", read_data, e);
            read_seen = 1'b1;
            last_read = e;
        end
        else if (read_seen)
            check_value(num, "read_data", read_data, last_read);   // held from the last read
        check_value(num, "sclk edges", edges, expected_edges(c));
        check_value(num, "cs_n windows", windows - win_before, 1);

        n_bits = host_bits(c);
        sent   = {24'h0, expected_opcode(c), a, w} >> (40 - n_bits);
        mask   = (64'd1 << n_bits) - 64'd1;
        got    = (rx_bits >> (edges - n_bits)) & mask;
        check_value(num, "io0 bits", got, sent);
        assert (bus_fault === 1'b0)
        else
        begin
            $display("test %0d: a pin was driven by the DUT while it should float", num);
            fail_count++;
        end

        $display("test %0d cmd %0d %s", num, c,
                 (fail_count == fails_before) ? "ok" : "had errors");
        if (fail_count != fails_before)
            bad_tests++;
    endtask

    initial
    begin
        start      = 1'b0;
        cmd_type   = qspi_pkg::CMD_WREN;
        addr       = '0;
        wr_data    = 8'h00;
        resp_byte  = 8'h00;
        fail_count = 0;
        bad_tests  = 0;
        read_seen  = 1'b0;
        last_read  = 8'h00;
        void'($urandom(32'h27866962));
        $readmemh("verification/qspi_vectors.txt", vec_mem);
        assert (!$isunknown(vec_mem[NUM_VEC*VEC_COLS-1]))
        else
        begin
            $display("vector file is missing or holds fewer than %0d vectors", NUM_VEC);
            fail_count++;
        end

        wait (I_rst_n === 1'b1);
        @(negedge I_clk_25M);
        check_reset();
        for (int i = 0; i < NUM_VEC; i++)
            run_test(i);

        $display("tests %0d, tests failed %0d, checks failed %0d",
                 NUM_VEC + 1, bad_tests, fail_count);
        if (fail_count == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

    // watchdog
    initial
    begin
        #(WATCHDOG_NS);
        $display("watchdog expired before all commands completed");
        $display("Simulation failed");
        $finish;
    end

endmodule

/* verification/qspi_vectors.txt */
// cmd addr wr resp expect, all hex; cmd 0 wren 1 rdsr 2 se 3 pp 4 read 5 quad read
// resp is what the flash returns, expect is the byte read_data must show on reads
0 000000 00 00 00
1 000000 00 A5 A5
2 123456 00 00 00
3 ABCDEF 5A 00 00
4 00FF00 00 C3 C3
5 7E8001 00 96 96
0 000000 00 00 00
3 000001 FF 00 00
4 FFFFFF 00 01 01
5 000000 00 F0 F0
1 000000 00 80 80
2 FEDCBA 00 00 00
5 A5A5A5 00 3C 3C
4 800000 00 7E 7E

/* list.f */
+incdir+common
common/qspi_pkg.sv
qspi_phy/qspi_shifter.sv
qspi_phy/qspi_capture.sv
verilog/qspi_sequencer.sv
verilog/qspi_top.sv
verification/tb_clock_gen.sv
verification/tb_flash_model.sv
verification/tb_qspi_top.sv

/* Bender.yml */
package:
  name: qspi_flash_driver

export_include_dirs:
  - common

sources:
  - common/qspi_pkg.sv
  - qspi_phy/qspi_shifter.sv
  - qspi_phy/qspi_capture.sv
  - verilog/qspi_sequencer.sv
  - verilog/qspi_top.sv
  - target: test
    files:
      - verification/tb_clock_gen.sv
      - verification/tb_flash_model.sv
      - verification/tb_qspi_top.sv
